// File: filelist.f
+incdir+testbench
source/rpn_pkg.sv
source/number_accumulator.sv
source/operator_stack.sv
source/rpn_queue.sv
source/parser_fsm.sv
source/rpn_parser_top.sv
testbench/tb_rpn_parser.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass message in the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_rpn_parser -f filelist.f \
   -o tb_rpn_parser > build.log 2>&1 \
   || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/tb_rpn_parser > sim.log 2>&1 ; cat sim.log

grep -qx "All checks passed" sim.log \
   && { echo "PASS"; exit 0; } \
   || { echo "FAIL"; exit 1; }

// File: testbench/tb_expr_table.svh
`ifndef TB_EXPR_TABLE_SVH
`define TB_EXPR_TABLE_SVH

// ==============================
// Expression table
// ==============================
localparam int NUM_ROWS    = 12;
localparam int MAX_ENTRIES = 9;

// Operator entries carry the tag in bit 16 and the opcode in bits 2..0.
localparam logic [ENTRY_WIDTH-1:0] E_ADD = 17'h10000;
localparam logic [ENTRY_WIDTH-1:0] E_SUB = 17'h10001;
localparam logic [ENTRY_WIDTH-1:0] E_MUL = 17'h10002;
localparam logic [ENTRY_WIDTH-1:0] E_DIV = 17'h10003;
localparam logic [ENTRY_WIDTH-1:0] E_POW = 17'h10004;
localparam logic [ENTRY_WIDTH-1:0] E_VAR = 17'h10006;
localparam logic [ENTRY_WIDTH-1:0] PAD   = 17'h00000;  // Unused slot.

// The responder sends the null end marker after the last character.
string expr_tab [NUM_ROWS] = '{
   "12.5",
   "3",
   "7.125",
   "1+2*3",
   "8/2/2",
   "9-4+1",
   "2**3**2",
   "[1+2]*x",
   "1 q+ 2z",
   "1+2]",
   "[1",
   "1+2+3+4+5"
};

// Numbers are {0, integer byte, two BCD fraction digits}.
logic [ENTRY_WIDTH-1:0] exp_entries [NUM_ROWS][MAX_ENTRIES] = '{
   '{17'h00C50, PAD, PAD, PAD, PAD, PAD, PAD, PAD, PAD},
   '{17'h00300, PAD, PAD, PAD, PAD, PAD, PAD, PAD, PAD},
   '{17'h00712, PAD, PAD, PAD, PAD, PAD, PAD, PAD, PAD},
   '{17'h00100, 17'h00200, 17'h00300, E_MUL, E_ADD, PAD, PAD, PAD, PAD},
   '{17'h00800, 17'h00200, E_DIV, 17'h00200, E_DIV, PAD, PAD, PAD, PAD},
   '{17'h00900, 17'h00400, E_SUB, 17'h00100, E_ADD, PAD, PAD, PAD, PAD},
   '{17'h00200, 17'h00300, 17'h00200, E_POW, E_POW, PAD, PAD, PAD, PAD},
   '{17'h00100, 17'h00200, E_ADD, E_VAR, E_MUL, PAD, PAD, PAD, PAD},
   '{17'h00100, 17'h00200, E_ADD, PAD, PAD, PAD, PAD, PAD, PAD},
   '{17'h00100, 17'h00200, E_ADD, PAD, PAD, PAD, PAD, PAD, PAD},
   '{17'h00100, PAD, PAD, PAD, PAD, PAD, PAD, PAD, PAD},
   '{17'h00100, 17'h00200, E_ADD, 17'h00300, E_ADD, 17'h00400, E_ADD, 17'h00500, PAD}
};

int exp_count [NUM_ROWS] = '{1, 1, 1, 5, 5, 5, 5, 5, 3, 3, 1, 8};  // Last row loses its 9th entry.
bit exp_error [NUM_ROWS] = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 1};

`endif

// File: testbench/tb_rpn_parser.sv
`timescale 1ns/1ns

module tb_rpn_parser
   import rpn_pkg::*;
();

   localparam int STACK_DEPTH  = 16;
   localparam int QUEUE_DEPTH  = 8;               // Small enough to reach overflow.
   localparam int ADDR_W       = $clog2(QUEUE_DEPTH);
   localparam int CNT_W        = $clog2(QUEUE_DEPTH + 1);
   localparam int CLK_HALF     = 20;
   localparam int RESET_CYCLES = 16;
   localparam int MAX_DELAY    = 5;
   localparam int REQ_LATENCY  = 2;               // First request follows start this quickly.
   localparam int DONE_TIMEOUT = 2000;

   `include "tb_expr_table.svh"

   logic                    clk          = 1'b0;
   logic                    rst_n        = 1'b0;
   logic                    start        = 1'b0;
   logic [SYMBOL_WIDTH-1:0] symbol       = '0;
   logic                    symbol_valid = 1'b0;
   logic [ADDR_W-1:0]       rd_index     = '0;
   logic                    symbol_req;
   logic                    done;
   logic                    parse_error;
   logic [ENTRY_WIDTH-1:0]  rd_entry;
   logic [CNT_W-1:0]        entry_count;

   int cur_row      = 0;
   int sym_idx      = 0;
   int resp_wait    = 0;
   bit resp_busy    = 1'b0;
   bit req_prev     = 1'b0;
   int entry_errors = 0;
   int count_errors = 0;
   int flag_errors  = 0;
   int req_errors   = 0;
   int timeouts     = 0;

   rpn_parser_top #(
      .STACK_DEPTH (STACK_DEPTH),
      .QUEUE_DEPTH (QUEUE_DEPTH)
   ) u_dut (
      .clk          (clk),
      .rst_n        (rst_n),
      .start        (start),
      .symbol       (symbol),
      .symbol_valid (symbol_valid),
      .symbol_req   (symbol_req),
      .done         (done),
      .parse_error  (parse_error),
      .rd_index     (rd_index),
      .rd_entry     (rd_entry),
      .entry_count  (entry_count)
   );

   initial begin
      forever #CLK_HALF clk = ~clk;
   end

   // ==============================
   // Symbol source
   // ==============================
   function automatic logic [SYMBOL_WIDTH-1:0] symbol_at(input int row, input int idx);
      string s;
      s = expr_tab[row];
      if (idx < s.len())
         return s[idx];
      return 8'h00;  // Null end marker.
   endfunction

   always @(posedge clk) begin
      symbol_valid <= 1'b0;
      if (symbol_req && (req_prev || resp_busy)) begin
         req_errors++;
         $display("Row %0d: symbol_req asserted again before the symbol was answered",
                  cur_row);
      end
      req_prev = symbol_req;
      if (start) begin
         sym_idx   = 0;
         resp_busy = 1'b0;
      end else begin
         if (symbol_req && !resp_busy) begin
            resp_busy = 1'b1;
            resp_wait = $urandom % (MAX_DELAY + 1);
         end
         if (resp_busy) begin
            if (resp_wait == 0) begin
               resp_busy = 1'b0;
               symbol       <= symbol_at(cur_row, sym_idx);
               symbol_valid <= 1'b1;
               sym_idx      = sym_idx + 1;
            end else begin
               resp_wait = resp_wait - 1;
            end
         end
      end
   end

   // ==============================
   // Waits and compare tasks
   // ==============================
   task automatic wait_for_request(output bit seen);
      int cycles;
      seen   = 1'b0;
      cycles = 0;
      while (!seen && cycles < REQ_LATENCY) begin
         @(posedge clk);
         seen   = symbol_req;
         cycles = cycles + 1;
      end
   endtask

   task automatic wait_for_done(output bit seen);
      int cycles;
      seen   = 1'b0;
      cycles = 0;
      while (!seen && cycles < DONE_TIMEOUT) begin
         @(posedge clk);
         seen   = done;
         cycles = cycles + 1;
      end
   endtask

   task automatic check_entry(input int row, input int idx,
                              input logic [ENTRY_WIDTH-1:0] got,
                              input logic [ENTRY_WIDTH-1:0] exp);
      if (got !== exp) begin
         entry_errors++;
         $display("ERROR row %0d: rd_entry[%0d] = 0x%05h, expected 0x%05h", row, idx, got, exp);
      end
   endtask

   task automatic check_count(input int row, input logic [CNT_W-1:0] got,
                              input logic [CNT_W-1:0] exp);
      if (got !== exp) begin
         count_errors++;
         $display("ERROR row %0d: entry_count = 0x%0h, expected 0x%0h", row, got, exp);
      end
   endtask

   task automatic check_flag(input int row, input logic got, input logic exp);
      if (got !== exp) begin
         flag_errors++;
         $display("ERROR row %0d: parse_error = 0x%0h, expected 0x%0h", row, got, exp);
      end
   endtask

   // ==============================
   // Table loop
   // ==============================
   initial begin
      int row;
      int idx;
      bit req_seen;
      bit finished;
      void'($urandom(32'hf56e));
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
      for (row = 0; row < NUM_ROWS; row++) begin
         @(posedge clk);
         cur_row = row;
         start <= 1'b1;
         @(posedge clk);
         start <= 1'b0;
         wait_for_request(req_seen);
         if (!req_seen) begin
            req_errors++;
            $display("Row %0d: symbol_req did not pulse within %0d cycles of start",
                     row, REQ_LATENCY);
         end
         wait_for_done(finished);
         if (!finished) begin
            timeouts++;
            $display("Row %0d: done did not rise within %0d cycles", row, DONE_TIMEOUT);
            break;
         end
         check_flag(row, parse_error, exp_error[row]);
         check_count(row, entry_count, CNT_W'(exp_count[row]));
         for (idx = 0; idx < exp_count[row]; idx++) begin
            rd_index <= idx[ADDR_W-1:0];
            @(posedge clk);
            check_entry(row, idx, rd_entry, exp_entries[row][idx]);  // Read port settles first.
         end
      end
      $display("Summary: %0d entry errors, %0d count errors, %0d flag errors, %0d request errors, %0d timeouts",
               entry_errors, count_errors, flag_errors, req_errors, timeouts);
      if (entry_errors + count_errors + flag_errors + req_errors + timeouts == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

endmodule

// File: source/rpn_parser_top.sv
`timescale 1ns/1ns

module rpn_parser_top
   import rpn_pkg::*;
#(
   parameter int STACK_DEPTH = 16,
   parameter int QUEUE_DEPTH = 32
) (
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic                             start,
   input  logic [SYMBOL_WIDTH-1:0]          symbol,
   input  logic                             symbol_valid,
   output logic                             symbol_req,
   output logic                             done,
   output logic                             parse_error,
   input  logic [$clog2(QUEUE_DEPTH)-1:0]   rd_index,
   output logic [ENTRY_WIDTH-1:0]           rd_entry,
   output logic [$clog2(QUEUE_DEPTH+1)-1:0] entry_count
);

   logic [NUMBER_WIDTH-1:0] acc_value;
   logic                    acc_clear;
   logic                    acc_digit;
   logic                    acc_point;
   op_code_t                top_op;
   op_code_t                push_op;
   logic                    stack_empty;
   logic                    stack_full;
   logic                    push;
   logic                    pop;
   logic                    clear;          // Start of a parse empties stack and queue.
   logic                    wr_en;
   logic [ENTRY_WIDTH-1:0]  wr_entry;
   logic                    queue_full;

   parser_fsm u_fsm (
      .clk          (clk),
      .rst_n        (rst_n),
      .start        (start),
      .symbol       (symbol),
      .symbol_valid (symbol_valid),
      .acc_value    (acc_value),
      .top_op       (top_op),
      .stack_empty  (stack_empty),
      .stack_full   (stack_full),
      .queue_full   (queue_full),
      .symbol_req   (symbol_req),
      .acc_clear    (acc_clear),
      .acc_digit    (acc_digit),
      .acc_point    (acc_point),
      .push         (push),
      .pop          (pop),
      .push_op      (push_op),
      .clear        (clear),
      .wr_en        (wr_en),
      .wr_entry     (wr_entry),
      .done         (done),
      .parse_error  (parse_error)
   );

   number_accumulator u_acc (
      .clk       (clk),
      .rst_n     (rst_n),
      .acc_clear (acc_clear),
      .acc_digit (acc_digit),
      .acc_point (acc_point),
      .symbol    (symbol),
      .acc_value (acc_value)
   );

   operator_stack #(.STACK_DEPTH(STACK_DEPTH)) u_stack (
      .clk     (clk),
      .rst_n   (rst_n),
      .clear   (clear),
      .push    (push),
      .pop     (pop),
      .push_op (push_op),
      .top_op  (top_op),
      .empty   (stack_empty),
      .full    (stack_full)
   );

   rpn_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
      .clk      (clk),
      .rst_n    (rst_n),
      .clear    (clear),
      .wr_en    (wr_en),
      .wr_entry (wr_entry),
      .rd_index (rd_index),
      .rd_entry (rd_entry),
      .count    (entry_count),
      .full     (queue_full)
   );

endmodule

// File: source/parser_fsm.sv
`timescale 1ns/1ns

module parser_fsm
   import rpn_pkg::*;
(
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    start,
   input  logic [SYMBOL_WIDTH-1:0] symbol,
   input  logic                    symbol_valid,
   input  logic [NUMBER_WIDTH-1:0] acc_value,
   input  op_code_t                top_op,
   input  logic                    stack_empty,
   input  logic                    stack_full,
   input  logic                    queue_full,
   output logic                    symbol_req,
   output logic                    acc_clear,
   output logic                    acc_digit,
   output logic                    acc_point,
   output logic                    push,
   output logic                    pop,
   output op_code_t                push_op,
   output logic                    clear,
   output logic                    wr_en,
   output logic [ENTRY_WIDTH-1:0]  wr_entry,
   output logic                    done,
   output logic                    parse_error
);

   parser_state_t           state;
   parser_state_t           loop_state;    // Where a pop loop goes back to.
   parser_state_t           resume_state;  // Where to go after a push.
   logic [SYMBOL_WIDTH-1:0] sym_reg;
   op_code_t                op_reg;
   logic                    in_number;
   logic                    pending_ast;
   logic                    err_reg;
   logic                    is_digit;
   logic                    is_num_sym;
   logic                    start_ok;

   function automatic op_code_t op_of(input logic [SYMBOL_WIDTH-1:0] sym);
      case (sym)
         "+":     return op_plus;
         "-":     return op_sub;
         "/":     return op_div;
         "[":     return op_lbracket;
         default: return op_var;
      endcase
   endfunction

   function automatic logic [ENTRY_WIDTH-1:0] op_entry(input op_code_t op);
      return {1'b1, {(ENTRY_WIDTH-4){1'b0}}, op};
   endfunction

   assign is_digit   = (symbol >= "0") && (symbol <= "9");
   assign is_num_sym = is_digit || (symbol == ".");
   assign start_ok   = start && (state == st_idle || state == st_done);

   // ==============================
   // Strobes to the data modules
   // ==============================
   assign symbol_req  = (state == st_request);
   assign clear       = start_ok;
   assign acc_clear   = start_ok || (state == st_emit_num);
   assign acc_digit   = (state == st_wait) && symbol_valid && is_digit;  // Live symbol.
   assign acc_point   = (state == st_wait) && symbol_valid && (symbol == ".");
   assign push        = (state == st_push) && !stack_full;
   assign push_op     = op_reg;
   assign pop         = ((state == st_pop_emit) && !queue_full) ||
                        ((state == st_rbracket) && !stack_empty && top_op == op_lbracket);
   assign wr_en       = !queue_full && (state inside {st_emit_num, st_emit_var, st_pop_emit});
   assign done        = (state == st_done);
   assign parse_error = err_reg;

   always_comb begin
      case (state)
         st_emit_num: wr_entry = {1'b0, acc_value};
         st_emit_var: wr_entry = op_entry(op_var);
         default:     wr_entry = op_entry(top_op);
      endcase
   end

   always_ff @(posedge clk) begin
      if (state == st_wait && symbol_valid) begin
         sym_reg <= symbol;
         op_reg  <= (symbol == "*") ? op_pow : op_mul;  // Resolves a pending asterisk.
      end else if (state == st_analyse) begin
         op_reg <= op_of(sym_reg);
      end
   end

   // ==============================
   // Shunting-yard sequencing
   // ==============================
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state        <= st_idle;
         loop_state   <= st_idle;
         resume_state <= st_idle;
         in_number    <= 1'b0;
         pending_ast  <= 1'b0;
         err_reg      <= 1'b0;
      end else if (start_ok) begin
         state       <= st_request;
         in_number   <= 1'b0;
         pending_ast <= 1'b0;
         err_reg     <= 1'b0;
      end else begin
         case (state)
            st_request: state <= st_wait;
            st_wait: begin
               if (symbol_valid) begin
                  if (is_num_sym)
                     in_number <= 1'b1;
                  if (pending_ast && symbol == "*") begin
                     pending_ast  <= 1'b0;
                     resume_state <= st_request;
                     state        <= st_push;
                  end else if (pending_ast) begin
                     pending_ast  <= 1'b0;
                     resume_state <= is_num_sym ? st_request : st_analyse;
                     state        <= st_mul_div;
                  end else if (is_num_sym) begin
                     state <= st_request;
                  end else if (in_number) begin
                     state <= st_emit_num;  // Terminator is analysed after the number.
                  end else begin
                     state <= st_analyse;
                  end
               end
            end
            st_analyse: begin
               resume_state <= st_request;
               case (sym_reg)
                  8'h00:    state <= st_flush;
                  "+", "-": state <= st_plus_sub;
                  "*": begin
                     pending_ast <= 1'b1;
                     state       <= st_request;
                  end
                  "/":      state <= st_mul_div;
                  "[":      state <= st_push;
                  "]":      state <= st_rbracket;
                  "x":      state <= st_emit_var;
                  default:  state <= st_request;
               endcase
            end
            st_emit_num: begin
               in_number <= 1'b0;
               err_reg   <= queue_full;
               state     <= queue_full ? st_done : st_analyse;
            end
            st_emit_var: begin
               err_reg <= queue_full;
               state   <= queue_full ? st_done : st_request;
            end
            st_plus_sub: begin
               if (!stack_empty && top_op != op_lbracket) begin
                  loop_state <= st_plus_sub;
                  state      <= st_pop_emit;
               end else begin
                  state <= st_push;
               end
            end
            st_mul_div: begin
               if (!stack_empty && top_op inside {op_mul, op_div, op_pow}) begin
                  loop_state <= st_mul_div;
                  state      <= st_pop_emit;
               end else begin
                  state <= st_push;
               end
            end
            st_push: begin
               err_reg <= stack_full;
               state   <= stack_full ? st_done : resume_state;
            end
            st_rbracket: begin
               if (stack_empty) begin
                  err_reg <= 1'b1;  // Closing bracket without an opening one.
                  state   <= st_done;
               end else if (top_op == op_lbracket) begin
                  state <= st_request;
               end else begin
                  loop_state <= st_rbracket;
                  state      <= st_pop_emit;
               end
            end
            st_flush: begin
               if (stack_empty) begin
                  state <= st_done;
               end else if (top_op == op_lbracket) begin
                  err_reg <= 1'b1;
                  state   <= st_done;
               end else begin
                  loop_state <= st_flush;
                  state      <= st_pop_emit;
               end
            end
            st_pop_emit: begin
               err_reg <= queue_full;
               state   <= queue_full ? st_done : loop_state;
            end
            st_idle, st_done: state <= state;
            default:          state <= st_idle;
         endcase
      end
   end

endmodule

// File: source/rpn_queue.sv
`timescale 1ns/1ns

module rpn_queue
   import rpn_pkg::*;
#(
   parameter int QUEUE_DEPTH = 32
) (
   input  logic                               clk,
   input  logic                               rst_n,
   input  logic                               clear,
   input  logic                               wr_en,
   input  logic [ENTRY_WIDTH-1:0]             wr_entry,
   input  logic [$clog2(QUEUE_DEPTH)-1:0]     rd_index,
   output logic [ENTRY_WIDTH-1:0]             rd_entry,
   output logic [$clog2(QUEUE_DEPTH+1)-1:0]   count,
   output logic                               full
);

   localparam int ADDR_W = $clog2(QUEUE_DEPTH);
   localparam int CNT_W  = $clog2(QUEUE_DEPTH + 1);

   logic [ENTRY_WIDTH-1:0] queue_mem [QUEUE_DEPTH];
   logic                   accept;

   assign full     = (count == CNT_W'(QUEUE_DEPTH));
   assign accept   = wr_en && !full && !clear;
   assign rd_entry = queue_mem[rd_index];      // Combinational read for the outside.

   // ==============================
   // Write index
   // ==============================
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         count <= '0;
      else if (clear)
         count <= '0;
      else if (accept)
         count <= count + 1'b1;
   end

   always_ff @(posedge clk) begin
      if (accept)
         queue_mem[ADDR_W'(count)] <= wr_entry;  // Entries kept in write order.
   end

endmodule

// File: source/operator_stack.sv
`timescale 1ns/1ns

module operator_stack
   import rpn_pkg::*;
#(
   parameter int STACK_DEPTH = 16
) (
   input  logic     clk,
   input  logic     rst_n,
   input  logic     clear,
   input  logic     push,
   input  logic     pop,
   input  op_code_t push_op,
   output op_code_t top_op,
   output logic     empty,
   output logic     full
);

   localparam int PTR_W  = $clog2(STACK_DEPTH + 1);
   localparam int ADDR_W = $clog2(STACK_DEPTH);

   op_code_t         stack_mem [STACK_DEPTH];
   logic [PTR_W-1:0] ptr;                        // Number of operators held.

   assign empty  = (ptr == '0);
   assign full   = (ptr == PTR_W'(STACK_DEPTH));
   assign top_op = stack_mem[ADDR_W'(ptr - 1'b1)];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         ptr <= '0;
      else if (clear)
         ptr <= '0;
      else if (push && !full)
         ptr <= ptr + 1'b1;
      else if (pop && !empty)
         ptr <= ptr - 1'b1;
   end

   always_ff @(posedge clk) begin
      if (push && !full && !clear)
         stack_mem[ADDR_W'(ptr)] <= push_op;
   end

endmodule

// File: source/number_accumulator.sv
`timescale 1ns/1ns

module number_accumulator
   import rpn_pkg::*;
(
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    acc_clear,
   input  logic                    acc_digit,
   input  logic                    acc_point,
   input  logic [SYMBOL_WIDTH-1:0] symbol,
   output logic [NUMBER_WIDTH-1:0] acc_value
);

   logic [INT_WIDTH-1:0]    int_part;
   logic [FRAC_WIDTH-1:0]   frac_part;
   logic                    frac_mode;
   logic [1:0]              frac_cnt;
   logic [SYMBOL_WIDTH-1:0] digit_value;

   assign digit_value = symbol - "0";  // ASCII digit to its binary value.
   assign acc_value   = {int_part, frac_part};

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         frac_mode <= 1'b0;
         frac_cnt  <= 2'd0;
      end else if (acc_clear) begin
         frac_mode <= 1'b0;
         frac_cnt  <= 2'd0;
      end else begin
         if (acc_point)
            frac_mode <= 1'b1;
         if (acc_digit && frac_mode && frac_cnt != 2'd2)
            frac_cnt <= frac_cnt + 2'd1;  // Saturates after the second fraction digit.
      end
   end

   always_ff @(posedge clk) begin
      if (acc_clear) begin
         int_part  <= '0;
         frac_part <= '0;
      end else if (acc_digit && !frac_mode) begin
         int_part <= int_part * INT_WIDTH'(10) + INT_WIDTH'(digit_value);  // Wraps modulo 256.
      end else if (acc_digit && frac_cnt == 2'd0) begin
         frac_part[FRAC_WIDTH-1 -: 4] <= digit_value[3:0];
      end else if (acc_digit && frac_cnt == 2'd1) begin
         frac_part[FRAC_WIDTH/2-1 -: 4] <= digit_value[3:0];
      end
   end

endmodule

// File: source/rpn_pkg.sv
package rpn_pkg;

   // ==============================
   // Widths
   // ==============================
   localparam int SYMBOL_WIDTH = 8;
   localparam int INT_WIDTH    = 8;
   localparam int FRAC_WIDTH   = 8;                      // Two BCD digits, first one on top.
   localparam int NUMBER_WIDTH = INT_WIDTH + FRAC_WIDTH;
   localparam int ENTRY_WIDTH  = NUMBER_WIDTH + 1;       // Top bit set marks an operator entry.

   // ==============================
   // Operators and parser states
   // ==============================
   typedef enum logic [2:0] {
      op_plus,
      op_sub,
      op_mul,
      op_div,
      op_pow,
      op_lbracket,
      op_var
   } op_code_t;

   typedef enum logic [4:0] {
      st_idle,
      st_request,
      st_wait,
      st_analyse,
      st_emit_num,
      st_emit_var,
      st_plus_sub,
      st_mul_div,
      st_push,
      st_rbracket,
      st_flush,
      st_pop_emit,
      st_done
   } parser_state_t;

endpackage
